/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int xlen = 32;

  // base opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_op_imm = 7'b0010011;
  localparam logic [6:0] op_op     = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // access size, loads and stores
  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  typedef enum logic [2:0] {
    st_fetch,
    st_wait_fetch,
    st_execute,
    st_wait_load,
    st_wait_store,
    st_trap
  } core_state_e;

  typedef logic [3:0] wstrb_t;

  function automatic logic [xlen-1:0] boot_addr_of(input logic [xlen-1:0] base,
                                                   input logic [xlen-1:0] stride,
                                                   input int unsigned idx);
    return base + stride * idx[xlen-1:0];
  endfunction

  // byte lanes touched by a store
  function automatic wstrb_t store_strobe(input logic [2:0] funct3, input logic [1:0] lane);
    wstrb_t base;
    case (funct3)
      f3_byte: base = 4'b0001;
      f3_half: base = 4'b0011;
      default: base = 4'b1111;
    endcase
    return base << lane;
  endfunction

  function automatic logic access_misaligned(input logic [2:0] funct3, input logic [1:0] lane);
    case (funct3[1:0])
      f3_half[1:0]: return lane[0];
      f3_word[1:0]: return lane != 2'b00;
      default:      return 1'b0;
    endcase
  endfunction

endpackage

`default_nettype wire

/* src/rv_mem_if.sv */
`default_nettype none

// one picorv32-style request port
interface rv_mem_if;

  logic                    valid;
  logic                    instr;
  logic                    ready;
  logic [rv_pkg::xlen-1:0] addr;
  logic [rv_pkg::xlen-1:0] wdata;
  rv_pkg::wstrb_t          wstrb;
  logic [rv_pkg::xlen-1:0] rdata;

  modport core (
    output valid, instr, addr, wdata, wstrb,
    input  ready, rdata
  );

  modport arbiter (
    input  valid, instr, addr, wdata, wstrb,
    output ready, rdata
  );

endinterface

`default_nettype wire

/* src/rv_core.sv */
`default_nettype none

module rv_core #(
  parameter logic [rv_pkg::xlen-1:0] boot_addr = '0
) (
  input  logic   clk,
  input  logic   reset,
  rv_mem_if.core mem,
  output logic   trap
);

  rv_pkg::core_state_e state;

  logic [rv_pkg::xlen-1:0] regs [32];
  logic [rv_pkg::xlen-1:0] pc;
  logic [rv_pkg::xlen-1:0] instr;

  logic [6:0] opcode;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic [4:0] rs2;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  logic [rv_pkg::xlen-1:0] rs1_val;
  logic [rv_pkg::xlen-1:0] rs2_val;

  // x0 is hardwired
  assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

  logic [rv_pkg::xlen-1:0] imm;

  always_comb begin
    case (opcode)
      rv_pkg::op_store:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      rv_pkg::op_branch: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      rv_pkg::op_lui,
      rv_pkg::op_auipc:  imm = {instr[31:12], 12'b0};
      rv_pkg::op_jal:    imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      default:           imm = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

  logic [rv_pkg::xlen-1:0] alu_b;
  logic [rv_pkg::xlen-1:0] alu_result;
  logic [4:0]              shamt;
  logic                    alt;

  assign alu_b = (opcode == rv_pkg::op_op) ? rs2_val : imm;
  assign shamt = alu_b[4:0];
  // funct7 bit 5 picks sub and sra
  assign alt   = funct7[5];

  always_comb begin
    case (funct3)
      rv_pkg::f3_add: begin
        if (opcode == rv_pkg::op_op && alt) begin
          alu_result = rs1_val - alu_b;
        end else begin
          alu_result = rs1_val + alu_b;
        end
      end
      rv_pkg::f3_sll:  alu_result = rs1_val << shamt;
      rv_pkg::f3_slt:  alu_result = {31'b0, $signed(rs1_val) < $signed(alu_b)};
      rv_pkg::f3_sltu: alu_result = {31'b0, rs1_val < alu_b};
      rv_pkg::f3_xor:  alu_result = rs1_val ^ alu_b;
      rv_pkg::f3_sr: begin
        if (alt) begin
          alu_result = $signed(rs1_val) >>> shamt;
        end else begin
          alu_result = rs1_val >> shamt;
        end
      end
      rv_pkg::f3_or:   alu_result = rs1_val | alu_b;
      default:         alu_result = rs1_val & alu_b;
    endcase
  end

  logic branch_taken;

  always_comb begin
    case (funct3)
      rv_pkg::f3_beq:  branch_taken = rs1_val == rs2_val;
      rv_pkg::f3_bne:  branch_taken = rs1_val != rs2_val;
      rv_pkg::f3_blt:  branch_taken = $signed(rs1_val) < $signed(rs2_val);
      rv_pkg::f3_bge:  branch_taken = $signed(rs1_val) >= $signed(rs2_val);
      rv_pkg::f3_bltu: branch_taken = rs1_val < rs2_val;
      rv_pkg::f3_bgeu: branch_taken = rs1_val >= rs2_val;
      default:         branch_taken = 1'b0;
    endcase
  end

  logic [rv_pkg::xlen-1:0] pc_plus4;
  logic [rv_pkg::xlen-1:0] pc_target;
  logic [rv_pkg::xlen-1:0] jalr_target;
  logic [rv_pkg::xlen-1:0] next_pc;

  assign pc_plus4    = pc + 32'd4;
  assign pc_target   = pc + imm;
  assign jalr_target = (rs1_val + imm) & ~32'd1;

  always_comb begin
    case (opcode)
      rv_pkg::op_jal:    next_pc = pc_target;
      rv_pkg::op_jalr:   next_pc = jalr_target;
      rv_pkg::op_branch: next_pc = branch_taken ? pc_target : pc_plus4;
      default:           next_pc = pc_plus4;
    endcase
  end

  logic [rv_pkg::xlen-1:0] ls_addr;
  logic                    is_load;
  logic                    is_store;
  logic                    is_jump;

  assign ls_addr  = rs1_val + imm;
  assign is_load  = opcode == rv_pkg::op_load;
  assign is_store = opcode == rv_pkg::op_store;
  assign is_jump  = opcode == rv_pkg::op_jal || opcode == rv_pkg::op_jalr ||
                    opcode == rv_pkg::op_branch;

  logic illegal;

  always_comb begin
    case (opcode)
      rv_pkg::op_lui,
      rv_pkg::op_auipc,
      rv_pkg::op_jal:    illegal = 1'b0;
      rv_pkg::op_jalr:   illegal = funct3 != 3'b000;
      rv_pkg::op_branch: illegal = funct3[2:1] == 2'b01;
      rv_pkg::op_load:   illegal = funct3 == 3'b011 || funct3[2:1] == 2'b11;
      rv_pkg::op_store:  illegal = funct3 > rv_pkg::f3_word;
      rv_pkg::op_op_imm: begin
        if (funct3 == rv_pkg::f3_sll) begin
          illegal = funct7 != 7'h00;
        end else if (funct3 == rv_pkg::f3_sr) begin
          illegal = funct7 != 7'h00 && funct7 != 7'h20;
        end else begin
          illegal = 1'b0;
        end
      end
      rv_pkg::op_op: begin
        illegal = !(funct7 == 7'h00 || (funct7 == 7'h20 &&
                    (funct3 == rv_pkg::f3_add || funct3 == rv_pkg::f3_sr)));
      end
      // ecall and ebreak end the program
      rv_pkg::op_system: illegal = 1'b1;
      default:           illegal = 1'b1;
    endcase
  end

  logic exec_trap;

  assign exec_trap = illegal ||
                     (is_jump && next_pc[1:0] != 2'b00) ||
                     ((is_load || is_store) &&
                      rv_pkg::access_misaligned(funct3, ls_addr[1:0]));

  logic                    wb_en;
  logic [rv_pkg::xlen-1:0] wb_value;

  always_comb begin
    wb_en = 1'b1;
    case (opcode)
      rv_pkg::op_lui:    wb_value = imm;
      rv_pkg::op_auipc:  wb_value = pc_target;
      rv_pkg::op_jal,
      rv_pkg::op_jalr:   wb_value = pc_plus4;
      rv_pkg::op_op,
      rv_pkg::op_op_imm: wb_value = alu_result;
      default: begin
        wb_en    = 1'b0;
        wb_value = alu_result;
      end
    endcase
  end

  // load data from its lane, then extended
  logic [rv_pkg::xlen-1:0] load_shifted;
  logic [rv_pkg::xlen-1:0] load_value;

  assign load_shifted = mem.rdata >> {mem.addr[1:0], 3'b000};

  always_comb begin
    case (funct3)
      rv_pkg::f3_byte:   load_value = {{24{load_shifted[7]}}, load_shifted[7:0]};
      rv_pkg::f3_half:   load_value = {{16{load_shifted[15]}}, load_shifted[15:0]};
      rv_pkg::f3_byte_u: load_value = {24'b0, load_shifted[7:0]};
      rv_pkg::f3_half_u: load_value = {16'b0, load_shifted[15:0]};
      default:           load_value = load_shifted;
    endcase
  end

  logic                    reg_we;
  logic [rv_pkg::xlen-1:0] reg_wdata;

  assign reg_we = (state == rv_pkg::st_execute && !exec_trap && wb_en) ||
                  (state == rv_pkg::st_wait_load && mem.ready);
  assign reg_wdata = (state == rv_pkg::st_wait_load) ? load_value : wb_value;

  always_ff @(posedge clk) begin
    if (reg_we && rd != 5'd0) begin
      regs[rd] <= reg_wdata;
    end
  end

  // request fields, held while valid is up
  always_ff @(posedge clk) begin
    if (state == rv_pkg::st_fetch) begin
      mem.addr  <= pc;
      mem.instr <= 1'b1;
      mem.wstrb <= '0;
    end else if (state == rv_pkg::st_execute) begin
      mem.addr  <= ls_addr;
      mem.instr <= 1'b0;
      mem.wdata <= rs2_val << {ls_addr[1:0], 3'b000};
      mem.wstrb <= is_store ? rv_pkg::store_strobe(funct3, ls_addr[1:0]) : '0;
    end
    if (state == rv_pkg::st_wait_fetch && mem.ready) begin
      instr <= mem.rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      state     <= rv_pkg::st_fetch;
      pc        <= boot_addr;
      mem.valid <= 1'b0;
    end else begin
      case (state)
        rv_pkg::st_fetch: begin
          mem.valid <= 1'b1;
          state     <= rv_pkg::st_wait_fetch;
        end
        rv_pkg::st_wait_fetch: begin
          if (mem.ready) begin
            mem.valid <= 1'b0;
            state     <= rv_pkg::st_execute;
          end
        end
        rv_pkg::st_execute: begin
          if (exec_trap) begin
            state <= rv_pkg::st_trap;
          end else begin
            pc <= next_pc;
            if (is_load) begin
              mem.valid <= 1'b1;
              state     <= rv_pkg::st_wait_load;
            end else if (is_store) begin
              mem.valid <= 1'b1;
              state     <= rv_pkg::st_wait_store;
            end else begin
              state <= rv_pkg::st_fetch;
            end
          end
        end
        rv_pkg::st_wait_load,
        rv_pkg::st_wait_store: begin
          if (mem.ready) begin
            mem.valid <= 1'b0;
            state     <= rv_pkg::st_fetch;
          end
        end
        rv_pkg::st_trap: state <= rv_pkg::st_trap;
        default:         state <= rv_pkg::st_trap;
      endcase
    end
  end

  assign trap = state == rv_pkg::st_trap;

  a_valid_held: assert property (@(posedge clk) disable iff (!reset)
    mem.valid && !mem.ready |=> mem.valid);

  a_addr_stable: assert property (@(posedge clk) disable iff (!reset)
    mem.valid && !mem.ready |=> $stable(mem.addr));

  a_no_req_in_trap: assert property (@(posedge clk) disable iff (!reset)
    state == rv_pkg::st_trap |-> !mem.valid);

endmodule

`default_nettype wire

/* src/rv_mem_arbiter.sv */
`default_nettype none

module rv_mem_arbiter #(
  parameter int n_cores = 4
) (
  input  logic                    clk,
  input  logic                    reset,
  rv_mem_if.arbiter               cores [n_cores],
  output logic                    bus_valid,
  output logic                    bus_instr,
  output logic [rv_pkg::xlen-1:0] bus_addr,
  output logic [rv_pkg::xlen-1:0] bus_wdata,
  output rv_pkg::wstrb_t          bus_wstrb,
  input  logic                    bus_ready,
  input  logic [rv_pkg::xlen-1:0] bus_rdata
);

  localparam int idx_w = (n_cores > 1) ? $clog2(n_cores) : 1;

  logic [n_cores-1:0]      req_valid;
  logic [n_cores-1:0]      req_instr;
  logic [n_cores-1:0]      core_ready;
  logic [rv_pkg::xlen-1:0] req_addr  [n_cores];
  logic [rv_pkg::xlen-1:0] req_wdata [n_cores];
  rv_pkg::wstrb_t          req_wstrb [n_cores];

  logic [idx_w-1:0] grant_idx;
  logic [idx_w-1:0] rr_ptr;
  logic [idx_w-1:0] pick_idx;
  logic             grant_active;
  logic             pick_found;

  for (genvar i = 0; i < n_cores; i++) begin : g_port
    assign req_valid[i]   = cores[i].valid;
    assign req_instr[i]   = cores[i].instr;
    assign req_addr[i]    = cores[i].addr;
    assign req_wdata[i]   = cores[i].wdata;
    assign req_wstrb[i]   = cores[i].wstrb;
    // ready goes to the granted core only
    assign core_ready[i]  = grant_active && grant_idx == idx_w'(i) && bus_ready;
    assign cores[i].ready = core_ready[i];
    assign cores[i].rdata = bus_rdata;
  end

  // first requester after the last grant wins
  always_comb begin
    int cand;
    pick_idx   = rr_ptr;
    pick_found = 1'b0;
    for (int k = n_cores; k >= 1; k--) begin
      cand = (int'(rr_ptr) + k) % n_cores;
      if (req_valid[cand]) begin
        pick_idx   = idx_w'(cand);
        pick_found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      grant_active <= 1'b0;
      grant_idx    <= '0;
      rr_ptr       <= idx_w'(n_cores - 1);
    end else if (grant_active) begin
      if (bus_valid && bus_ready) begin
        grant_active <= 1'b0;
        rr_ptr       <= grant_idx;
      end
    end else if (pick_found) begin
      grant_active <= 1'b1;
      grant_idx    <= pick_idx;
    end
  end

  assign bus_valid = grant_active && req_valid[grant_idx];
  assign bus_instr = req_instr[grant_idx];
  assign bus_addr  = req_addr[grant_idx];
  assign bus_wdata = req_wdata[grant_idx];
  assign bus_wstrb = req_wstrb[grant_idx];

  a_ready_onehot: assert property (@(posedge clk) disable iff (!reset)
    $onehot0(core_ready) && (core_ready & ~req_valid) == '0);

  a_grant_held: assert property (@(posedge clk) disable iff (!reset)
    bus_valid && !bus_ready |=> bus_valid && $stable(grant_idx));

endmodule

`default_nettype wire

/* src/rv_cluster.sv */
`default_nettype none

module rv_cluster #(
  parameter int                      n_cores     = 4,
  parameter logic [rv_pkg::xlen-1:0] boot_base   = '0,
  parameter logic [rv_pkg::xlen-1:0] boot_stride = 32'h400
) (
  input  logic                    clk,
  input  logic                    reset,
  output logic                    mem_valid,
  output logic                    mem_instr,
  output logic [rv_pkg::xlen-1:0] mem_addr,
  output logic [rv_pkg::xlen-1:0] mem_wdata,
  output rv_pkg::wstrb_t          mem_wstrb,
  input  logic                    mem_ready,
  input  logic [rv_pkg::xlen-1:0] mem_rdata,
  output logic [n_cores-1:0]      trap
);

  rv_mem_if core_if [n_cores] ();

  // core i boots at base + i * stride
  for (genvar i = 0; i < n_cores; i++) begin : g_core
    rv_core #(
      .boot_addr(rv_pkg::boot_addr_of(boot_base, boot_stride, i))
    ) core_i (
      .clk  (clk),
      .reset(reset),
      .mem  (core_if[i]),
      .trap (trap[i])
    );
  end

  rv_mem_arbiter #(
    .n_cores(n_cores)
  ) arbiter_i (
    .clk      (clk),
    .reset    (reset),
    .cores    (core_if),
    .bus_valid(mem_valid),
    .bus_instr(mem_instr),
    .bus_addr (mem_addr),
    .bus_wdata(mem_wdata),
    .bus_wstrb(mem_wstrb),
    .bus_ready(mem_ready),
    .bus_rdata(mem_rdata)
  );

endmodule

`default_nettype wire

/* testbench/rv_cluster_tb.sv */
`default_nettype none

module rv_cluster_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_cores = 4;
  localparam logic [31:0] boot_base = 32'h0;
  localparam logic [31:0] boot_stride = 32'h400;
  localparam int max_stores = 32;

  logic        clk;
  logic        reset;
  logic        mem_valid;
  logic        mem_instr;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wstrb;
  logic        mem_ready;
  logic [31:0] mem_rdata;
  logic [3:0]  trap;

  rv_cluster #(
    .n_cores    (n_cores),
    .boot_base  (boot_base),
    .boot_stride(boot_stride)
  ) rv_cluster_i (
    .clk      (clk),
    .reset    (reset),
    .mem_valid(mem_valid),
    .mem_instr(mem_instr),
    .mem_addr (mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb),
    .mem_ready(mem_ready),
    .mem_rdata(mem_rdata),
    .trap     (trap)
  );

  logic [31:0] mem_words [1024];
  logic [31:0] exp_addr [n_cores][max_stores];
  logic [31:0] exp_data [n_cores][max_stores];
  logic [3:0]  exp_strb [n_cores][max_stores];
  int          exp_cnt [n_cores];
  int          got_cnt [n_cores];
  logic [3:0]  trap_exp;
  logic [3:0]  fetch_seen;
  int          errs [1:6];
  int          total_stores;
  bit          loaded;
  logic [31:0] rng_state;
  int          wait_left;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic read_stim();
    int          fd;
    int          n;
    int          c;
    string       tag;
    string       rest;
    logic [31:0] a;
    logic [31:0] d;
    logic [3:0]  s;
    fd = $fopen("testbench/rv_cluster_stim.txt", "r");
    if (fd == 0) begin
      $display("stim file testbench/rv_cluster_stim.txt could not be opened");
      $display("Checks failed");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        n = $fscanf(fd, "%s", tag);
        if (n != 1) break;
        if (tag == "M") begin
          n = $fscanf(fd, "%h %h", a, d);
          mem_words[a[11:2]] = d;
        end else if (tag == "S") begin
          n = $fscanf(fd, "%d %h %h %h", c, a, d, s);
          exp_addr[c][exp_cnt[c]] = a;
          exp_data[c][exp_cnt[c]] = d;
          exp_strb[c][exp_cnt[c]] = s;
          exp_cnt[c]++;
          total_stores++;
        end else if (tag == "T") begin
          n = $fscanf(fd, "%d", c);
          trap_exp[c] = 1'b1;
        end else begin
          // comment line
          n = $fgets(rest, fd);
        end
      end
      $fclose(fd);
    end
  endtask

  // one transfer checked and applied where ready rises
  task automatic serve();
    int          r;
    int          k;
    int          t;
    logic [31:0] word;
    if (mem_addr >= 32'h1000) begin
      $display("transfer to address %h lies outside every core region", mem_addr);
      errs[3]++;
      mem_rdata = '0;
    end else begin
      r = int'(mem_addr[11:10]);
      t = (r == 3) ? 4 : 3;
      assert (!trap[r]) else begin
        $display("core %0d made a transfer after its trap was raised", r);
        errs[6]++;
      end
      if (!fetch_seen[r]) begin
        fetch_seen[r] = 1'b1;
        assert (mem_instr && mem_addr == boot_base + r * boot_stride) else begin
          $display("** Error: mem_addr = %h mem_instr = %h, expected boot fetch at %h",
                   mem_addr, mem_instr, boot_base + r * boot_stride);
          errs[2]++;
        end
      end
      word = mem_words[mem_addr[11:2]];
      mem_rdata = word;
      if (mem_wstrb != 4'h0) begin
        k = got_cnt[r];
        if (k >= exp_cnt[r]) begin
          $display("core %0d made more stores than expected", r);
          errs[t]++;
        end else begin
          assert (mem_addr == exp_addr[r][k]) else begin
            $display("** Error: mem_addr = %h, expected %h", mem_addr, exp_addr[r][k]);
            errs[t]++;
          end
          assert (mem_wdata == exp_data[r][k]) else begin
            $display("** Error: mem_wdata = %h, expected %h", mem_wdata, exp_data[r][k]);
            errs[t]++;
          end
          assert (mem_wstrb == exp_strb[r][k]) else begin
            $display("** Error: mem_wstrb = %h, expected %h", mem_wstrb, exp_strb[r][k]);
            errs[t]++;
          end
        end
        got_cnt[r]++;
        for (int b = 0; b < 4; b++) begin
          if (mem_wstrb[b]) word[b*8 +: 8] = mem_wdata[b*8 +: 8];
        end
        mem_words[mem_addr[11:2]] = word;
      end
    end
  endtask

  // memory model with 0 to 3 wait cycles
  initial begin
    mem_ready = 1'b0;
    mem_rdata = '0;
    wait_left = -1;
    @(posedge reset);
    forever begin
      @(negedge clk);
      if (mem_ready) begin
        mem_ready = 1'b0;
        wait_left = -1;
      end else if (mem_valid) begin
        if (wait_left < 0) wait_left = int'(next_rand() % 4);
        if (wait_left == 0) begin
          serve();
          mem_ready = 1'b1;
        end else begin
          wait_left--;
        end
      end
    end
  end

  // bus transfers seen while a core waits for its grant
  for (genvar i = 0; i < n_cores; i++) begin : g_starve
    int waited = 0;
    always @(posedge clk) begin
      if (!reset || rv_cluster_i.core_if[i].ready || !rv_cluster_i.core_if[i].valid) begin
        waited <= 0;
      end else if (mem_valid && mem_ready) begin
        waited <= waited + 1;
      end
      assert (waited <= n_cores) else begin
        $display("core %0d waited for more than %0d transfers", i, n_cores);
        errs[5]++;
      end
    end
  end

  initial begin
    int limit;
    wait (loaded);
    limit = total_stores * 200 + 1000;
    repeat (limit) @(posedge clk);
    $display("timeout after %0d cycles, cores did not all reach their traps", limit);
    $display("Checks failed");
    $finish;
  end

  initial begin
    string names [1:6];
    int    total;
    int    passed;
    names[1] = "reset state";
    names[2] = "boot fetch";
    names[3] = "alu and branch stores";
    names[4] = "sub-word access";
    names[5] = "arbitration";
    names[6] = "traps";
    reset        = 1'b0;
    trap_exp     = '0;
    fetch_seen   = '0;
    total_stores = 0;
    rng_state    = 32'hf314;
    for (int i = 1; i <= 6; i++) errs[i] = 0;
    for (int i = 0; i < n_cores; i++) begin
      exp_cnt[i] = 0;
      got_cnt[i] = 0;
    end
    for (int i = 0; i < 1024; i++) mem_words[i] = {i[15:0], 16'hffff};
    read_stim();
    loaded = 1'b1;
    repeat (4) @(negedge clk);
    reset = 1'b1;
    repeat (2) begin
      assert (mem_valid == 1'b0 && trap == '0) else begin
        $display("** Error: mem_valid = %h trap = %h, expected 0", mem_valid, trap);
        errs[1]++;
      end
      @(negedge clk);
    end
    wait ((trap & trap_exp) == trap_exp);
    repeat (20) @(negedge clk);
    for (int i = 0; i < n_cores; i++) begin
      assert (fetch_seen[i]) else begin
        $display("no fetch from core %0d was seen", i);
        errs[2]++;
      end
      assert (got_cnt[i] == exp_cnt[i]) else begin
        $display("core %0d made %0d stores, expected %0d", i, got_cnt[i], exp_cnt[i]);
        errs[5]++;
      end
      assert (trap[i] == trap_exp[i]) else begin
        $display("** Error: trap[%0d] = %h, expected %h", i, trap[i], trap_exp[i]);
        errs[6]++;
      end
    end
    total  = 0;
    passed = 0;
    for (int i = 1; i <= 6; i++) begin
      $display("test %0d %s: %s, %0d errors", i, names[i],
               (errs[i] == 0) ? "pass" : "FAIL", errs[i]);
      total += errs[i];
      if (errs[i] == 0) passed++;
    end
    $display("%0d of 6 tests passed, %0d errors", passed, total);
    if (total == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/rv_cluster_stim.txt */
# M addr word : memory image
# S core addr wdata wstrb : expected store | T core : core must trap
M 00000000 00500093
M 00000004 ffd00113
M 00000008 002081b3
M 0000000c 10302023
M 00000010 40208233
M 00000014 10402223
M 00000018 001122b3
M 0000001c 10502423
M 00000020 00100073
S 0 00000100 00000002 f
S 0 00000104 00000008 f
S 0 00000108 00000001 f
T 0
M 00000400 800000b7
M 00000404 4040d113
M 00000408 0040d193
M 0000040c 00314233
M 00000410 50402023
M 00000414 00001297
M 00000418 00229313
M 0000041c 50602223
M 00000420 00100073
S 1 00000500 f0000000 f
S 1 00000504 00005050 f
T 1
M 00000800 00000093
M 00000804 00300113
M 00000808 00708093
M 0000080c fff10113
M 00000810 fe011ce3
M 00000814 40000193
M 00000818 5011a023
M 0000081c 00100073
S 2 00000900 00000015 f
T 2
M 00000c00 000011b7
M 00000c04 d0018193
M 00000c08 8a500093
M 00000c0c 001180a3
M 00000c10 00119323
M 00000c14 001181a3
M 00000c18 00118203
M 00000c1c 0041a823
M 00000c20 0031c283
M 00000c24 0051aa23
M 00000c28 00619303
M 00000c2c 0061ac23
M 00000c30 0061d383
M 00000c34 0071ae23
M 00000c38 0021a403
S 3 00000d01 fff8a500 2
S 3 00000d06 f8a50000 c
S 3 00000d03 a5000000 8
S 3 00000d10 ffffffa5 f
S 3 00000d14 000000a5 f
S 3 00000d18 fffff8a5 f
S 3 00000d1c 0000f8a5 f
T 3

/* rv_cluster.f */
src/rv_pkg.sv
src/rv_mem_if.sv
src/rv_core.sv
src/rv_mem_arbiter.sv
src/rv_cluster.sv
testbench/rv_cluster_tb.sv

/* Bender.yml */
package:
  name: rv_cluster

sources:
  - src/rv_pkg.sv
  - src/rv_mem_if.sv
  - src/rv_core.sv
  - src/rv_mem_arbiter.sv
  - src/rv_cluster.sv
  - target: test
    files:
      - testbench/rv_cluster_tb.sv
